// File: admm_pkg.sv
package admm_pkg;

    // Q8.8 samples on a 32-bit word bus
    localparam int DATA_W    = 16;
    localparam int FRAC_BITS = 8;
    localparam int BUS_W     = 32;
    localparam int ADDR_W    = 8;
    localparam int N_ELEM    = 8;
    localparam int IDX_W     = 3;
    localparam int ITER_W    = 16;

    // Headroom for a three-term sum of samples
    localparam int SUM_W = DATA_W + 2;
    localparam logic signed [SUM_W-1:0] DATA_MAX = SUM_W'((2 ** (DATA_W - 1)) - 1);
    localparam logic signed [SUM_W-1:0] DATA_MIN = SUM_W'(-(2 ** (DATA_W - 1)));
    localparam logic signed [SUM_W-1:0] MAG_MAX  = SUM_W'((2 ** DATA_W) - 1);

    // Scalar registers, word addresses
    localparam logic [ADDR_W-1:0] REG_CTRL     = ADDR_W'(0);
    localparam logic [ADDR_W-1:0] REG_STATUS   = ADDR_W'(1);
    localparam logic [ADDR_W-1:0] REG_ITER     = ADDR_W'(2);
    localparam logic [ADDR_W-1:0] REG_TOL      = ADDR_W'(3);
    localparam logic [ADDR_W-1:0] REG_MAX_ITER = ADDR_W'(4);
    localparam logic [ADDR_W-1:0] REG_PRI_RES  = ADDR_W'(5);
    localparam logic [ADDR_W-1:0] REG_DUAL_RES = ADDR_W'(6);

    // Vector blocks of N_ELEM words each
    localparam logic [ADDR_W-1:0] BASE_REF = ADDR_W'(8);
    localparam logic [ADDR_W-1:0] BASE_LO  = ADDR_W'(16);
    localparam logic [ADDR_W-1:0] BASE_HI  = ADDR_W'(24);
    localparam logic [ADDR_W-1:0] BASE_X   = ADDR_W'(32);
    localparam logic [ADDR_W-1:0] BASE_Z   = ADDR_W'(40);

    typedef enum logic [2:0] {
        IDLE,
        X_UPDATE,
        Z_UPDATE,
        Y_UPDATE,
        CHECK,
        DONE
    } solver_state_t;

    typedef enum logic [1:0] {
        NOP,
        RD,
        WR
    } bus_op_t;

    typedef struct packed {
        logic              chipselect;
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [BUS_W-1:0]  writedata;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] tol;
        logic [ITER_W-1:0] max_iter;
    } solve_cfg_t;

    typedef struct packed {
        logic              busy;
        logic              done;
        logic              converged;
        logic [ITER_W-1:0] iter;
    } solver_status_t;

    typedef struct packed {
        logic [DATA_W-1:0] pri_mag;
        logic [DATA_W-1:0] dual_mag;
    } resid_sample_t;

    // Saturate a wide sum back to a signed sample
    function automatic logic signed [DATA_W-1:0] sat_data(input logic signed [SUM_W-1:0] v);
        if (v > DATA_MAX) begin
            return DATA_MAX[DATA_W-1:0];
        end
        if (v < DATA_MIN) begin
            return DATA_MIN[DATA_W-1:0];
        end
        return v[DATA_W-1:0];
    endfunction

    // Unsigned magnitude, clipped to the sample width
    function automatic logic [DATA_W-1:0] mag_data(input logic signed [SUM_W-1:0] v);
        logic signed [SUM_W-1:0] a;
        a = (v < 0) ? -v : v;
        if (a > MAG_MAX) begin
            return '1;
        end
        return a[DATA_W-1:0];
    endfunction

endpackage

// File: admm_regs.sv
`timescale 1ns/1ps

module admm_regs import admm_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  bus_req_t                 req,
    output logic [BUS_W-1:0]         readdata,
    input  solver_status_t           status,
    input  logic [DATA_W-1:0]        pri_res,
    input  logic [DATA_W-1:0]        dual_res,
    input  logic signed [DATA_W-1:0] x_rd,
    input  logic signed [DATA_W-1:0] z_rd,
    output logic                     start_pulse,
    output solve_cfg_t               cfg,
    output logic signed [DATA_W-1:0] ref_vec [N_ELEM],
    output logic signed [DATA_W-1:0] lo_vec [N_ELEM],
    output logic signed [DATA_W-1:0] hi_vec [N_ELEM],
    output logic [IDX_W-1:0]         rd_idx
);

    bus_op_t          op;
    logic [IDX_W-1:0] elem;
    logic             cfg_lock;
    logic             cfg_wr;
    logic [BUS_W-1:0] rd_mux;

    // True when addr falls in the N_ELEM-word block at base
    function automatic logic in_block(input logic [ADDR_W-1:0] a,
                                      input logic [ADDR_W-1:0] base);
        return a[ADDR_W-1:IDX_W] == base[ADDR_W-1:IDX_W];
    endfunction

    always_comb begin
        if (!req.chipselect) begin
            op = NOP;
        end else if (req.write) begin
            op = WR;
        end else if (req.read) begin
            op = RD;
        end else begin
            op = NOP;
        end
    end

    assign elem   = req.addr[IDX_W-1:0];
    assign rd_idx = elem;

    // Solve pending or running
    assign cfg_lock = status.busy || start_pulse;
    assign cfg_wr   = (op == WR) && !cfg_lock;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_pulse  <= 1'b0;
            cfg.tol      <= '0;
            cfg.max_iter <= ITER_W'(1);
        end else begin
            start_pulse <= (op == WR) && (req.addr == REG_CTRL) && req.writedata[0];
            if (cfg_wr && (req.addr == REG_TOL)) begin
                cfg.tol <= req.writedata[DATA_W-1:0];
            end
            if (cfg_wr && (req.addr == REG_MAX_ITER)) begin
                cfg.max_iter <= req.writedata[ITER_W-1:0];
            end
        end
    end

    // Problem vectors
    always_ff @(posedge clk) begin
        if (cfg_wr) begin
            if (in_block(req.addr, BASE_REF)) begin
                ref_vec[elem] <= req.writedata[DATA_W-1:0];
            end
            if (in_block(req.addr, BASE_LO)) begin
                lo_vec[elem] <= req.writedata[DATA_W-1:0];
            end
            if (in_block(req.addr, BASE_HI)) begin
                hi_vec[elem] <= req.writedata[DATA_W-1:0];
            end
        end
    end

    // Signed vectors are sign extended, everything else zero extended
    always_comb begin
        rd_mux = '0;
        if (in_block(req.addr, BASE_REF)) begin
            rd_mux = BUS_W'(ref_vec[elem]);
        end else if (in_block(req.addr, BASE_LO)) begin
            rd_mux = BUS_W'(lo_vec[elem]);
        end else if (in_block(req.addr, BASE_HI)) begin
            rd_mux = BUS_W'(hi_vec[elem]);
        end else if (in_block(req.addr, BASE_X)) begin
            rd_mux = BUS_W'(x_rd);
        end else if (in_block(req.addr, BASE_Z)) begin
            rd_mux = BUS_W'(z_rd);
        end else begin
            case (req.addr)
                REG_STATUS:   rd_mux = BUS_W'({status.converged, status.done, status.busy});
                REG_ITER:     rd_mux = BUS_W'(status.iter);
                REG_TOL:      rd_mux = BUS_W'(cfg.tol);
                REG_MAX_ITER: rd_mux = BUS_W'(cfg.max_iter);
                REG_PRI_RES:  rd_mux = BUS_W'(pri_res);
                REG_DUAL_RES: rd_mux = BUS_W'(dual_res);
                default:      rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            readdata <= '0;
        end else if (op == RD) begin
            readdata <= rd_mux;
        end
    end

endmodule

// File: admm_engine.sv
`timescale 1ns/1ps

module admm_engine import admm_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_pulse,
    input  solve_cfg_t               cfg,
    input  logic signed [DATA_W-1:0] ref_vec [N_ELEM],
    input  logic signed [DATA_W-1:0] lo_vec [N_ELEM],
    input  logic signed [DATA_W-1:0] hi_vec [N_ELEM],
    input  logic [IDX_W-1:0]         rd_idx,
    input  logic                     converged,
    output solver_status_t           status,
    output logic signed [DATA_W-1:0] x_rd,
    output logic signed [DATA_W-1:0] z_rd,
    output logic                     clear,
    output logic                     sample_valid,
    output resid_sample_t            sample
);

    solver_state_t     state;
    logic [IDX_W-1:0]  idx;
    logic [IDX_W-1:0]  idx_next;
    logic              last_elem;
    logic [ITER_W-1:0] iter;
    logic [ITER_W-1:0] iter_inc;
    logic [ITER_W-1:0] iter_limit;
    logic              conv_q;
    logic              busy;
    logic              start_ok;

    logic signed [DATA_W-1:0] x_mem [N_ELEM];
    logic signed [DATA_W-1:0] z_mem [N_ELEM];
    logic signed [DATA_W-1:0] y_mem [N_ELEM];
    logic signed [DATA_W-1:0] zprev_mem [N_ELEM];

    logic signed [DATA_W-1:0] ref_i;
    logic signed [DATA_W-1:0] lo_i;
    logic signed [DATA_W-1:0] hi_i;
    logic signed [DATA_W-1:0] x_i;
    logic signed [DATA_W-1:0] z_i;
    logic signed [DATA_W-1:0] y_i;
    logic signed [DATA_W-1:0] zprev_i;
    logic signed [SUM_W-1:0]  x_sum;
    logic signed [SUM_W-1:0]  v_sum;
    logic signed [SUM_W-1:0]  y_sum;
    logic signed [SUM_W-1:0]  pri_diff;
    logic signed [SUM_W-1:0]  dual_diff;
    logic signed [DATA_W-1:0] x_new;
    logic signed [DATA_W-1:0] z_new;
    logic signed [DATA_W-1:0] y_new;

    assign last_elem  = (idx == IDX_W'(N_ELEM - 1));
    assign idx_next   = last_elem ? '0 : idx + 1'b1;
    assign iter_inc   = iter + 1'b1;
    // A limit of zero still runs one iteration
    assign iter_limit = (cfg.max_iter == '0) ? ITER_W'(1) : cfg.max_iter;
    assign busy       = (state != IDLE) && (state != DONE);
    assign start_ok   = start_pulse && !busy;

    // One element per cycle, shared by all three stages
    always_comb begin
        ref_i   = ref_vec[idx];
        lo_i    = lo_vec[idx];
        hi_i    = hi_vec[idx];
        x_i     = x_mem[idx];
        z_i     = z_mem[idx];
        y_i     = y_mem[idx];
        zprev_i = zprev_mem[idx];

        // x = (ref + z - y) / (1 + rho) with rho of one
        x_sum = ref_i + z_i - y_i;
        x_new = sat_data(x_sum >>> 1);

        // Projection of x + y onto the box
        v_sum = x_i + y_i;
        if (v_sum < lo_i) begin
            z_new = lo_i;
        end else if (v_sum > hi_i) begin
            z_new = hi_i;
        end else begin
            z_new = v_sum[DATA_W-1:0];
        end

        y_sum = y_i + x_i - z_i;
        y_new = sat_data(y_sum);

        pri_diff  = x_i - z_new;
        dual_diff = z_new - zprev_i;
    end

    assign sample_valid    = (state == Z_UPDATE);
    assign clear           = sample_valid && (idx == '0);
    assign sample.pri_mag  = mag_data(pri_diff);
    assign sample.dual_mag = mag_data(dual_diff);

    assign status.busy      = busy;
    assign status.done      = (state == DONE);
    assign status.converged = conv_q;
    assign status.iter      = iter;

    assign x_rd = x_mem[rd_idx];
    assign z_rd = z_mem[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            idx    <= '0;
            iter   <= '0;
            conv_q <= 1'b0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start_ok) begin
                        state  <= X_UPDATE;
                        idx    <= '0;
                        iter   <= '0;
                        conv_q <= 1'b0;
                    end
                end
                X_UPDATE: begin
                    idx <= idx_next;
                    if (last_elem) begin
                        state <= Z_UPDATE;
                    end
                end
                Z_UPDATE: begin
                    idx <= idx_next;
                    if (last_elem) begin
                        state <= Y_UPDATE;
                    end
                end
                Y_UPDATE: begin
                    idx <= idx_next;
                    if (last_elem) begin
                        state <= CHECK;
                    end
                end
                CHECK: begin
                    iter <= iter_inc;
                    if (converged || (iter_inc >= iter_limit)) begin
                        state  <= DONE;
                        conv_q <= converged;
                    end else begin
                        state <= X_UPDATE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Vector stores, zeroed by an accepted start
    always_ff @(posedge clk) begin
        if (start_ok) begin
            for (int i = 0; i < N_ELEM; i++) begin
                x_mem[i]     <= '0;
                z_mem[i]     <= '0;
                y_mem[i]     <= '0;
                zprev_mem[i] <= '0;
            end
        end else begin
            case (state)
                X_UPDATE: begin
                    x_mem[idx]     <= x_new;
                    // Snapshot of z before this iteration's projection
                    zprev_mem[idx] <= z_i;
                end
                Z_UPDATE: z_mem[idx] <= z_new;
                Y_UPDATE: y_mem[idx] <= y_new;
                default: ;
            endcase
        end
    end

endmodule

// File: admm_residual.sv
`timescale 1ns/1ps

module admm_residual import admm_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  logic              sample_valid,
    input  resid_sample_t     sample,
    input  logic [DATA_W-1:0] tol,
    output logic              converged,
    output logic [DATA_W-1:0] pri_res,
    output logic [DATA_W-1:0] dual_res
);

    logic [IDX_W-1:0]  cnt;
    logic [IDX_W-1:0]  cnt_base;
    logic [DATA_W-1:0] run_pri;
    logic [DATA_W-1:0] run_dual;
    logic [DATA_W-1:0] pri_base;
    logic [DATA_W-1:0] dual_base;
    logic [DATA_W-1:0] pri_next;
    logic [DATA_W-1:0] dual_next;

    // Clear arrives together with the first sample of a z-update
    always_comb begin
        cnt_base  = clear ? '0 : cnt;
        pri_base  = clear ? '0 : run_pri;
        dual_base = clear ? '0 : run_dual;
        pri_next  = (sample.pri_mag > pri_base) ? sample.pri_mag : pri_base;
        dual_next = (sample.dual_mag > dual_base) ? sample.dual_mag : dual_base;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt      <= '0;
            run_pri  <= '0;
            run_dual <= '0;
            pri_res  <= '0;
            dual_res <= '0;
        end else if (sample_valid) begin
            run_pri  <= pri_next;
            run_dual <= dual_next;
            cnt      <= cnt_base + 1'b1;
            // Last element of the z-update publishes the iteration
            if (cnt_base == IDX_W'(N_ELEM - 1)) begin
                pri_res  <= pri_next;
                dual_res <= dual_next;
            end
        end
    end

    assign converged = (pri_res <= tol) && (dual_res <= tol);

endmodule

// File: admm_solver.sv
`timescale 1ns/1ps

module admm_solver import admm_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  bus_req_t         req,
    output logic [BUS_W-1:0] readdata
);

    logic                     start_pulse;
    solve_cfg_t               cfg;
    logic signed [DATA_W-1:0] ref_vec [N_ELEM];
    logic signed [DATA_W-1:0] lo_vec [N_ELEM];
    logic signed [DATA_W-1:0] hi_vec [N_ELEM];
    logic [IDX_W-1:0]         rd_idx;
    solver_status_t           status;
    logic signed [DATA_W-1:0] x_rd;
    logic signed [DATA_W-1:0] z_rd;
    logic                     clear;
    logic                     sample_valid;
    resid_sample_t            sample;
    logic                     converged;
    logic [DATA_W-1:0]        pri_res;
    logic [DATA_W-1:0]        dual_res;

    // Bus decode and configuration
    admm_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .readdata    (readdata),
        .status      (status),
        .pri_res     (pri_res),
        .dual_res    (dual_res),
        .x_rd        (x_rd),
        .z_rd        (z_rd),
        .start_pulse (start_pulse),
        .cfg         (cfg),
        .ref_vec     (ref_vec),
        .lo_vec      (lo_vec),
        .hi_vec      (hi_vec),
        .rd_idx      (rd_idx)
    );

    admm_engine u_engine (
        .clk          (clk),
        .rst          (rst),
        .start_pulse  (start_pulse),
        .cfg          (cfg),
        .ref_vec      (ref_vec),
        .lo_vec       (lo_vec),
        .hi_vec       (hi_vec),
        .rd_idx       (rd_idx),
        .converged    (converged),
        .status       (status),
        .x_rd         (x_rd),
        .z_rd         (z_rd),
        .clear        (clear),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    // Residual maxima and convergence
    admm_residual u_residual (
        .clk          (clk),
        .rst          (rst),
        .clear        (clear),
        .sample_valid (sample_valid),
        .sample       (sample),
        .tol          (cfg.tol),
        .converged    (converged),
        .pri_res      (pri_res),
        .dual_res     (dual_res)
    );

endmodule

// File: admm_checker.sv
`timescale 1ns/1ps

module admm_checker import admm_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  bus_req_t         req,
    input  logic [BUS_W-1:0] readdata,
    input  logic [1:0]       exp_mode,
    input  logic [BUS_W-1:0] exp_val,
    output int               checks,
    output int               errors
);

    // Mirror of the configuration and the solver results
    int               m_ref [N_ELEM];
    int               m_lo [N_ELEM];
    int               m_hi [N_ELEM];
    int               m_x [N_ELEM];
    int               m_z [N_ELEM];
    int               m_tol;
    int               m_max;
    int               m_iter;
    int               m_pri;
    int               m_dual;
    logic             m_conv;
    logic             m_done;
    int               cyc;
    int               lock_end;
    logic             pending;
    logic             reset_seen;
    logic [ADDR_W-1:0] pend_addr;
    logic [BUS_W-1:0] pend_exp;

    function automatic int sat16(input int v);
        return (v > 32767) ? 32767 : (v < -32768) ? -32768 : v;
    endfunction

    function automatic int mag16(input int v);
        int a;
        a = (v < 0) ? -v : v;
        return (a > 65535) ? 65535 : a;
    endfunction

    function automatic logic [BUS_W-1:0] model_read(input logic [ADDR_W-1:0] a);
        int i;
        i = int'(a[2:0]);
        case (a[ADDR_W-1:3])
            5'd1: return BUS_W'(m_ref[i]);
            5'd2: return BUS_W'(m_lo[i]);
            5'd3: return BUS_W'(m_hi[i]);
            5'd4: return BUS_W'(m_x[i]);
            5'd5: return BUS_W'(m_z[i]);
            default: ;
        endcase
        case (a)
            8'd1: return {29'd0, m_conv, m_done, 1'b0};
            8'd2: return BUS_W'(m_iter);
            8'd3: return BUS_W'(m_tol);
            8'd4: return BUS_W'(m_max);
            8'd5: return BUS_W'(m_pri);
            8'd6: return BUS_W'(m_dual);
            default: return '0;
        endcase
    endfunction

    task automatic run_solve();
        int   y [N_ELEM];
        int   zp [N_ELEM];
        int   v;
        int   lim;
        int   pri;
        int   dual;
        logic stop;
        lim = (m_max == 0) ? 1 : m_max;
        for (int i = 0; i < N_ELEM; i++) begin
            m_x[i] = 0;
            m_z[i] = 0;
            y[i]   = 0;
        end
        m_iter = 0;
        stop   = 1'b0;
        while (!stop) begin
            for (int i = 0; i < N_ELEM; i++) begin
                zp[i]  = m_z[i];
                m_x[i] = sat16((m_ref[i] + m_z[i] - y[i]) >>> 1);
            end
            pri  = 0;
            dual = 0;
            for (int i = 0; i < N_ELEM; i++) begin
                v = m_x[i] + y[i];
                m_z[i] = (v < m_lo[i]) ? m_lo[i] : (v > m_hi[i]) ? m_hi[i] : v;
                pri  = (mag16(m_x[i] - m_z[i]) > pri) ? mag16(m_x[i] - m_z[i]) : pri;
                dual = (mag16(m_z[i] - zp[i]) > dual) ? mag16(m_z[i] - zp[i]) : dual;
            end
            for (int i = 0; i < N_ELEM; i++) begin
                y[i] = sat16(y[i] + m_x[i] - m_z[i]);
            end
            m_iter++;
            m_pri  = pri;
            m_dual = dual;
            m_conv = (pri <= m_tol) && (dual <= m_tol);
            stop   = m_conv || (m_iter >= lim);
        end
        m_done = 1'b1;
    endtask

    task automatic handle_write();
        logic cfg_locked;
        logic start_ignored;
        int   i;
        int   val;
        // Configuration held from the strobe through the last CHECK
        cfg_locked    = (cyc <= lock_end);
        // A start is dropped when its strobe meets a busy engine
        start_ignored = (cyc < lock_end);
        i             = int'(req.addr[2:0]);
        val           = int'($signed(req.writedata[15:0]));
        if (!cfg_locked) begin
            case (req.addr[ADDR_W-1:3])
                5'd1: m_ref[i] = val;
                5'd2: m_lo[i]  = val;
                5'd3: m_hi[i]  = val;
                default: ;
            endcase
            if (req.addr == REG_TOL) begin
                m_tol = int'(req.writedata[15:0]);
            end
            if (req.addr == REG_MAX_ITER) begin
                m_max = int'(req.writedata[15:0]);
            end
        end
        if (req.addr == REG_CTRL && req.writedata[0] && !start_ignored) begin
            run_solve();
            lock_end = cyc + 25 * m_iter + 1;
        end
    endtask

    task automatic compare(input logic [BUS_W-1:0] expected);
        checks++;
        if (readdata !== expected) begin
            errors++;
            $display("Error at %0t: address %0d read %h, expected %h",
                     $time, pend_addr, readdata, expected);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < N_ELEM; i++) begin
                m_ref[i] = 0;
                m_lo[i]  = 0;
                m_hi[i]  = 0;
                m_x[i]   = 0;
                m_z[i]   = 0;
            end
            {m_tol, m_iter, m_pri, m_dual} = '0;
            m_max      = 1;
            m_conv     = 1'b0;
            m_done     = 1'b0;
            cyc        = 0;
            lock_end   = -1;
            pending    = 1'b0;
            reset_seen = 1'b0;
            checks     = 0;
            errors     = 0;
        end else begin
            cyc++;
            if (!reset_seen) begin
                reset_seen = 1'b1;
                pend_addr  = '0;
                compare('0);
            end
            if (pending) begin
                compare(pend_exp);
            end
            pending = 1'b0;
            if (req.chipselect && req.write) begin
                handle_write();
            end else if (req.chipselect && req.read && exp_mode != 2'd0) begin
                pending   = 1'b1;
                pend_addr = req.addr;
                pend_exp  = (exp_mode == 2'd1) ? exp_val : model_read(req.addr);
            end
        end
    end

endmodule

// File: admm_assert.sv
`timescale 1ns/1ps

module admm_assert import admm_pkg::*; (
    input logic                     clk,
    input logic                     rst,
    input logic                     start_pulse,
    input solver_status_t           status,
    input solve_cfg_t               cfg,
    input bus_req_t                 req,
    input logic signed [DATA_W-1:0] z_val,
    input logic signed [DATA_W-1:0] lo_val,
    input logic signed [DATA_W-1:0] hi_val
);

    logic [ITER_W-1:0] limit;
    logic              z_read;

    assign limit  = (cfg.max_iter == '0) ? ITER_W'(1) : cfg.max_iter;
    assign z_read = req.chipselect && req.read
                    && (req.addr[ADDR_W-1:IDX_W] == BASE_Z[ADDR_W-1:IDX_W]);

    a_start_one_cycle: assert property (@(posedge clk) disable iff (rst)
        start_pulse |=> !start_pulse)
        else $error("start_pulse high for more than one cycle");

    a_busy_done: assert property (@(posedge clk) disable iff (rst)
        status.done |-> (!status.busy && status.iter != '0))
        else $error("done set while busy or before any iteration");

    // Checked while running and on the cycle a solve ends
    a_iter_limit: assert property (@(posedge clk) disable iff (rst)
        (status.busy || $rose(status.done)) |-> (status.iter <= limit))
        else $error("iteration count above max_iter");

    // Only the element on the read port is visible here
    a_z_in_box: assert property (@(posedge clk) disable iff (rst)
        (status.done && z_read) |-> (z_val >= lo_val && z_val <= hi_val))
        else $error("z element outside its bounds after a solve");

endmodule

bind admm_solver admm_assert a0 (
    .clk         (clk),
    .rst         (rst),
    .start_pulse (start_pulse),
    .status      (status),
    .cfg         (cfg),
    .req         (req),
    .z_val       (z_rd),
    .lo_val      (lo_vec[rd_idx]),
    .hi_val      (hi_vec[rd_idx])
);

// File: tb_admm.sv
`timescale 1ns/1ps

module tb_admm import admm_pkg::*; ();

    typedef struct packed {
        int          test;
        byte         op;
        logic [31:0] addr;
        logic [31:0] data;
        byte         chk;
        logic [31:0] arg;
    } step_t;

    logic             clk;
    logic             rst;
    bus_req_t         req;
    logic [BUS_W-1:0] readdata;
    logic [1:0]       exp_mode;
    logic [BUS_W-1:0] exp_val;
    int               checks;
    int               errors;
    step_t            steps [$];
    int               limit;
    int               cycles;
    int               tests;
    int               bad_ops;

    admm_solver dut0 (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .readdata (readdata)
    );

    admm_checker chk0 (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .readdata (readdata),
        .exp_mode (exp_mode),
        .exp_val  (exp_val),
        .checks   (checks),
        .errors   (errors)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the run went past %0d cycles", limit);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        int          t;
        byte         op;
        byte         chk;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] arg;
        step_t       s;
        fd = $fopen("admm_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file admm_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != 8'h23) begin
                    n = $sscanf(line, "%d %c %h %h %c %h", t, op, addr, data, chk, arg);
                    if (n == 6) begin
                        s = '{t, op, addr, data, chk, arg};
                        steps.push_back(s);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One bus cycle driven just after the rising edge
    task automatic drive(input logic rd, input logic wr, input logic [ADDR_W-1:0] addr,
                         input logic [BUS_W-1:0] data, input logic [1:0] mode,
                         input logic [BUS_W-1:0] val);
        @(posedge clk);
        #2;
        req.chipselect = rd | wr;
        req.read       = rd;
        req.write      = wr;
        req.addr       = addr;
        req.writedata  = data;
        exp_mode       = mode;
        exp_val        = val;
    endtask

    task automatic poll_done();
        logic done;
        done = 1'b0;
        // The engine sees the start two cycles after the CTRL write
        drive(1'b0, 1'b0, '0, '0, 2'd0, '0);
        while (!done) begin
            drive(1'b1, 1'b0, REG_STATUS, '0, 2'd0, '0);
            drive(1'b0, 1'b0, '0, '0, 2'd0, '0);
            done = readdata[1];
        end
    endtask

    initial begin
        int         prev_chk;
        int         prev_err;
        int         maxit;
        int         sum;
        int         ops;
        logic [1:0] mode;
        clk      = 1'b0;
        rst      = 1'b1;
        req      = '0;
        exp_mode = 2'd0;
        exp_val  = '0;
        cycles   = 0;
        limit    = 0;
        tests    = 0;
        bad_ops  = 0;
        load_trace();

        // Each solve runs at most max_iter iterations
        maxit = 1;
        sum   = 0;
        ops   = 10;
        foreach (steps[k]) begin
            if (steps[k].op == "w" && steps[k].addr == 32'(REG_MAX_ITER)) begin
                maxit = int'(steps[k].data[15:0]);
            end
            if (steps[k].op == "w" && steps[k].addr == 32'(REG_CTRL) && steps[k].data[0]) begin
                sum += ((maxit == 0) ? 1 : maxit) * 25 + 2;
            end
            ops += (steps[k].op == "b" || steps[k].op == "q") ? 8 : 2;
        end
        limit = 4 * (sum + ops);

        repeat (5) @(posedge clk);
        #2;
        rst      = 1'b0;
        prev_chk = 0;
        prev_err = 0;
        foreach (steps[k]) begin
            mode = (steps[k].chk == "x") ? 2'd1 : (steps[k].chk == "m") ? 2'd2 : 2'd0;
            case (steps[k].op)
                "r": drive(1'b1, 1'b0, steps[k].addr[7:0], '0, mode, steps[k].arg);
                "w": drive(1'b0, 1'b1, steps[k].addr[7:0], steps[k].data, 2'd0, '0);
                "b": begin
                    for (int i = 0; i < N_ELEM; i++) begin
                        drive(1'b0, 1'b1, ADDR_W'(steps[k].addr + i),
                              BUS_W'(16'(steps[k].data + i * steps[k].arg)), 2'd0, '0);
                    end
                end
                "q": begin
                    for (int i = 0; i < N_ELEM; i++) begin
                        drive(1'b1, 1'b0, ADDR_W'(steps[k].addr + i), '0, mode, '0);
                    end
                end
                "p": poll_done();
                "e": begin
                    // Let the last read come back before counting
                    drive(1'b0, 1'b0, '0, '0, 2'd0, '0);
                    drive(1'b0, 1'b0, '0, '0, 2'd0, '0);
                    tests++;
                    $display("Test %0d finished: %0d checks, %0d errors",
                             steps[k].test, checks - prev_chk, errors - prev_err);
                    prev_chk = checks;
                    prev_err = errors;
                end
                default: begin
                    $display("Unknown operation in trace line %0d", k);
                    bad_ops++;
                end
            endcase
        end
        drive(1'b0, 1'b0, '0, '0, 2'd0, '0);
        drive(1'b0, 1'b0, '0, '0, 2'd0, '0);
        $display("Totals: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && bad_ops == 0 && tests > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: admm_trace.txt
# test op addr data chk arg  (hex addr, data and arg)
# op r read, w write, b block write (word i = data + i*arg), q block read, p poll done, e end
# chk x exact (arg is expected), m model, d don't care
1 r 01 0000 x 00000000
1 r 02 0000 x 00000000
1 r 03 0000 x 00000000
1 r 04 0000 x 00000001
1 r 05 0000 x 00000000
1 r 06 0000 x 00000000
1 e 00 0000 d 0
2 w 03 0004 d 0
2 w 04 0040 d 0
2 b 08 fe00 d 80
2 b 10 f800 d 0
2 b 18 0800 d 0
2 r 03 0000 x 00000004
2 r 04 0000 x 00000040
2 r 08 0000 x fffffe00
2 r 0f 0000 x 00000180
2 r 10 0000 x fffff800
2 r 18 0000 x 00000800
2 q 08 0000 m 0
2 q 10 0000 m 0
2 q 18 0000 m 0
2 e 00 0000 d 0
3 w 00 0001 d 0
3 p 00 0000 d 0
3 r 01 0000 x 00000006
3 r 02 0000 m 0
3 r 05 0000 m 0
3 r 06 0000 m 0
3 q 20 0000 m 0
3 q 28 0000 m 0
3 e 00 0000 d 0
4 b 10 ff80 d 10
4 b 18 0040 d 10
4 w 00 0001 d 0
4 p 00 0000 d 0
4 r 01 0000 m 0
4 r 02 0000 m 0
4 r 05 0000 m 0
4 r 06 0000 m 0
4 q 28 0000 m 0
4 q 20 0000 m 0
4 e 00 0000 d 0
5 w 03 0000 d 0
5 w 04 0003 d 0
5 w 00 0001 d 0
5 p 00 0000 d 0
5 r 01 0000 m 0
5 r 02 0000 x 00000003
5 r 05 0000 m 0
5 r 06 0000 m 0
5 q 20 0000 m 0
5 e 00 0000 d 0
6 w 04 0005 d 0
6 w 03 0004 d 0
6 w 00 0001 d 0
6 w 03 0100 d 0
6 w 00 0001 d 0
6 p 00 0000 d 0
6 r 03 0000 x 00000004
6 r 04 0000 x 00000005
6 r 02 0000 m 0
6 r 01 0000 m 0
6 q 20 0000 m 0
6 q 28 0000 m 0
6 e 00 0000 d 0

// File: project.f
admm_pkg.sv
admm_regs.sv
admm_engine.sv
admm_residual.sv
admm_solver.sv
admm_checker.sv
admm_assert.sv
tb_admm.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_admm
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST) *.sv
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
